// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_decode_top
FILELIST  := project.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/tb_decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top import rv_pkg::*; ();

  localparam int num_inst      = 3000;
  localparam int reset_timeout = 20;  // cycles

  typedef struct packed {
    alu_op_e  op;
    alu_src_e src_a;
    alu_src_e src_b;
    wb_src_e  wb;
    logic     reg_we;
    logic     mem_write;
    logic     mem_read;
    logic     csr_we;
    logic     csr_rd;
  } ctrl_t;

  localparam ctrl_t ctrl_idle = '{ALU_NONE, SRC_REG, SRC_REG, WB_ALU, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

  logic              clk = 1'b0;
  logic              arst_n;
  logic [xlen-1:0]   pc;
  logic [ilen-1:0]   inst;
  logic              wb_we;
  logic [reg_aw-1:0] wb_addr;
  logic [xlen-1:0]   wb_data;
  logic [xlen-1:0]   ex_data_rs1, ex_data_rs2, ex_data_utype, ex_data_imm;
  logic [csr_aw-1:0] ex_csr_addr;
  logic [2:0]        ex_csr_func;
  alu_op_e           ex_alu_op;
  alu_src_e          ex_alu_src_a, ex_alu_src_b;
  wb_src_e           ex_mem_to_reg;
  logic              ex_reg_we, ex_mem_write, ex_mem_read, ex_csr_we, ex_csr_rd;
  logic              pc_src, id_flush;
  logic [xlen-1:0]   branch_pc_new;

  // reference state
  logic [xlen-1:0]   model_regs [32];
  logic              prev_pc_src;
  logic [31:0]       rng = 32'd56;
  int                fail_count;
  int                redirects;

  // packet expected at ex_* after the next edge
  logic [xlen-1:0]   exp_rs1, exp_rs2, exp_utype, exp_imm;
  logic [csr_aw-1:0] exp_csr_addr;
  logic [2:0]        exp_csr_func;
  ctrl_t             exp_ctrl;

  opcode_e opc_list [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR, OPC_BRANCH,
                             OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM};

  decode_top #(.DWIDTH(xlen), .PC_WIDTH(xlen)) DUT (.*);

  always #4 clk = ~clk;

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng = x;
    return x;
  endfunction

  // rv32i immediate formats
  function automatic logic [31:0] decode_imm(input logic [31:0] i);
    case (opcode_e'(i[6:0]))
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: return {{20{i[31]}}, i[31:20]};
      OPC_STORE:          return {{20{i[31]}}, i[31:25], i[11:7]};
      OPC_BRANCH:         return {{20{i[31]}}, i[7], i[30:25], i[11:8], 1'b0};
      OPC_LUI, OPC_AUIPC: return {i[31:12], 12'h000};
      OPC_JAL:            return {{12{i[31]}}, i[19:12], i[20], i[30:21], 1'b0};
      default:            return 32'h0;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      3'b000:  return a == b;
      3'b001:  return a != b;
      3'b100:  return $signed(a) < $signed(b);
      3'b101:  return $signed(a) >= $signed(b);
      3'b110:  return a < b;
      3'b111:  return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic ctrl_t control_row(input logic [31:0] i);
    ctrl_t c;
    c = ctrl_idle;
    case (opcode_e'(i[6:0]))
      OPC_LUI:    c = '{ALU_ADD, SRC_ZERO, SRC_IMM, WB_ALU, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OPC_AUIPC:  c = '{ALU_ADD, SRC_PC, SRC_IMM, WB_ALU, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OPC_JAL, OPC_JALR: begin
        c = '{ALU_ADD, SRC_PC, SRC_IMM, WB_PC4, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      end
      OPC_BRANCH: c = '{ALU_SUB_CMP, SRC_REG, SRC_REG, WB_ALU, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
      OPC_LOAD:   c = '{ALU_ADD, SRC_REG, SRC_IMM, WB_MEM, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
      OPC_STORE:  c = '{ALU_ADD, SRC_REG, SRC_IMM, WB_ALU, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
      OPC_OP_IMM: c = '{ALU_FUNCT, SRC_REG, SRC_IMM, WB_ALU, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OPC_OP:     c = '{ALU_FUNCT, SRC_REG, SRC_REG, WB_ALU, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0};
      OPC_SYSTEM: begin
        if (i[13:12] != 2'b00) begin  // any csr op reads the csr
          c = '{ALU_NONE, SRC_REG, SRC_ZERO, WB_CSR, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
        end
        // csrrw always writes, set and clear only with a nonzero rs1
        c.csr_we = (i[13:12] == 2'b01) || (i[13] && (i[19:15] != 5'd0));
      end
      default: c = ctrl_idle;
    endcase
    return c;
  endfunction

  task automatic expect_equal(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    assert (act === exp) else begin
      fail_count++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
      $display("TEST FAIL");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic verify_controls(input ctrl_t c);
    expect_equal("ex_alu_op", 32'(c.op), 32'(ex_alu_op));
    expect_equal("ex_alu_src_a", 32'(c.src_a), 32'(ex_alu_src_a));
    expect_equal("ex_alu_src_b", 32'(c.src_b), 32'(ex_alu_src_b));
    expect_equal("ex_mem_to_reg", 32'(c.wb), 32'(ex_mem_to_reg));
    expect_equal("ex_reg_we", 32'(c.reg_we), 32'(ex_reg_we));
    expect_equal("ex_mem_write", 32'(c.mem_write), 32'(ex_mem_write));
    expect_equal("ex_mem_read", 32'(c.mem_read), 32'(ex_mem_read));
    expect_equal("ex_csr_we", 32'(c.csr_we), 32'(ex_csr_we));
    expect_equal("ex_csr_rd", 32'(c.csr_rd), 32'(ex_csr_rd));
  endtask

  task automatic compare_ex_packet();
    expect_equal("ex_data_rs1", exp_rs1, ex_data_rs1);
    expect_equal("ex_data_rs2", exp_rs2, ex_data_rs2);
    expect_equal("ex_data_utype", exp_utype, ex_data_utype);
    expect_equal("ex_data_imm", exp_imm, ex_data_imm);
    expect_equal("ex_csr_addr", 32'(exp_csr_addr), 32'(ex_csr_addr));
    expect_equal("ex_csr_func", 32'(exp_csr_func), 32'(ex_csr_func));
    verify_controls(exp_ctrl);
  endtask

  // new instruction and write-back traffic for the coming cycle
  task automatic drive_random_inst();
    int          idx;
    logic [31:0] bits;
    logic [31:0] pc_v;
    logic [31:0] r;
    idx  = int'(next_random() % 32'd10);
    bits = next_random();
    pc_v = next_random();
    r    = next_random();
    inst    <= {bits[31:7], opc_list[idx]};
    pc      <= {pc_v[31:2], 2'b00};
    wb_we   <= (r[1:0] == 2'b00);
    wb_addr <= r[6:2];  // x0 included on purpose
    wb_data <= r[7] ? next_random() : {28'h0, r[11:8]};  // small values make equal operands
  endtask

  // same-cycle checks, then the packet due one cycle later
  task automatic predict_decode();
    opcode_e         opc;
    logic [xlen-1:0] rs1v, rs2v, imm, base;
    logic            exp_pc_src;
    opc  = opcode_e'(inst[6:0]);
    rs1v = model_regs[inst[19:15]];
    rs2v = model_regs[inst[24:20]];
    imm  = decode_imm(inst);
    exp_pc_src = (opc == OPC_JAL) || (opc == OPC_JALR) ||
                 ((opc == OPC_BRANCH) && branch_taken(inst[14:12], rs1v, rs2v));
    base = (opc == OPC_JALR) ? rs1v : pc;
    expect_equal("pc_src", 32'(exp_pc_src), 32'(pc_src));
    expect_equal("id_flush", 32'(exp_pc_src), 32'(id_flush));
    expect_equal("branch_pc_new", base + imm, branch_pc_new);

    exp_rs1      = rs1v;
    exp_rs2      = rs2v;
    exp_utype    = (opc == OPC_AUIPC) ? pc : '0;
    exp_imm      = ((opc == OPC_JAL) || (opc == OPC_JALR)) ? 32'd4 : imm;
    exp_csr_addr = inst[31:20];
    exp_csr_func = inst[14:12];
    exp_ctrl     = prev_pc_src ? ctrl_idle : control_row(inst);  // slot behind a redirect
    if (exp_pc_src) begin
      redirects++;
    end
    prev_pc_src = exp_pc_src;
    if (wb_we && (wb_addr != '0)) begin
      model_regs[wb_addr] = wb_data;  // visible from the next cycle
    end
  endtask

  initial begin
    int wait_cnt;
    arst_n  <= 1'b0;
    pc      <= '0;
    inst    <= '0;
    wb_we   <= 1'b0;
    wb_addr <= '0;
    wb_data <= '0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    prev_pc_src = 1'b0;
    fail_count  = 0;
    redirects   = 0;
    // inst 0 decodes to an idle packet with zero data
    exp_rs1      = '0;
    exp_rs2      = '0;
    exp_utype    = '0;
    exp_imm      = '0;
    exp_csr_addr = '0;
    exp_csr_func = '0;
    exp_ctrl     = ctrl_idle;

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    wait_cnt = 0;
    while (arst_n !== 1'b1) begin
      if (wait_cnt >= reset_timeout) begin
        $display("timeout while waiting for reset release");
        $display("TEST FAIL");
        $fatal(1, "reset timeout");
      end else begin
        @(negedge clk);
        wait_cnt++;
      end
    end
    verify_controls(ctrl_idle);

    for (int n = 0; n < num_inst; n++) begin
      @(posedge clk);
      drive_random_inst();
      @(negedge clk);
      compare_ex_packet();  // previous instruction
      predict_decode();
    end
    @(posedge clk);
    inst  <= '0;
    wb_we <= 1'b0;
    @(negedge clk);
    compare_ex_packet();

    $display("%0d instructions decoded, %0d redirects", num_inst, redirects);
    if (fail_count == 0) begin
      $display("TEST PASS");
      $finish;
    end else begin
      $display("TEST FAIL");
      $fatal(1, "%0d checks failed", fail_count);
    end
  end

endmodule

`default_nettype wire

// File: project.f
src/rv_pkg.sv
src/reg_file.sv
src/imm_gen.sv
src/control_unit.sv
src/branch_cmp.sv
src/hazard_unit.sv
src/decode_stage.sv
src/id_ex_reg.sv
src/decode_top.sv
dv/tb_decode_top.sv

// File: src/branch_cmp.sv
`timescale 1ns/100ps
`default_nettype none

module branch_cmp import rv_pkg::*; #(
  parameter int DWIDTH = xlen
) (
  input  logic [DWIDTH-1:0] rs1,
  input  logic [DWIDTH-1:0] rs2,
  input  logic [2:0]        funct3,
  output logic              taken
);

  always_comb begin
    case (branch_f3_e'(funct3))
      F3_BEQ:  taken = (rs1 == rs2);
      F3_BNE:  taken = (rs1 != rs2);
      F3_BLT:  taken = ($signed(rs1) < $signed(rs2));
      F3_BGE:  taken = ($signed(rs1) >= $signed(rs2));
      F3_BLTU: taken = (rs1 < rs2);
      F3_BGEU: taken = (rs1 >= rs2);
      default: taken = 1'b0;  // 010 and 011 are not branches
    endcase
  end

endmodule

`default_nettype wire

// File: src/control_unit.sv
`timescale 1ns/100ps
`default_nettype none

module control_unit import rv_pkg::*; (
  input  logic [ilen-1:0] inst,
  output alu_op_e         alu_op,
  output alu_src_e        alu_src_a,
  output alu_src_e        alu_src_b,
  output wb_src_e         mem_to_reg,
  output logic            reg_we,
  output logic            mem_write,
  output logic            mem_read,
  output logic            branch,
  output logic            jump,
  output logic            jalr_sel,
  output logic            utype_sel,
  output logic            jlink_sel,
  output logic            csr_we,
  output logic            csr_rd
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       rs1_nz;

  assign opcode = opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign rs1_nz = |inst[19:15];

  always_comb begin
    // idle row, also what an unknown opcode gets
    alu_op     = ALU_NONE;
    alu_src_a  = SRC_REG;
    alu_src_b  = SRC_REG;
    mem_to_reg = WB_ALU;
    reg_we     = 1'b0;
    mem_write  = 1'b0;
    mem_read   = 1'b0;
    branch     = 1'b0;
    jump       = 1'b0;
    jalr_sel   = 1'b0;
    utype_sel  = 1'b0;
    jlink_sel  = 1'b0;
    csr_we     = 1'b0;
    csr_rd     = 1'b0;

    case (opcode)
      OPC_LUI: begin
        alu_op    = ALU_ADD;
        alu_src_a = SRC_ZERO;
        alu_src_b = SRC_IMM;
        reg_we    = 1'b1;
      end
      OPC_AUIPC: begin
        alu_op    = ALU_ADD;
        alu_src_a = SRC_PC;
        alu_src_b = SRC_IMM;
        reg_we    = 1'b1;
        utype_sel = 1'b1;
      end
      OPC_JAL, OPC_JALR: begin
        alu_op     = ALU_ADD;  // pc + 4 for the link
        alu_src_a  = SRC_PC;
        alu_src_b  = SRC_IMM;
        mem_to_reg = WB_PC4;
        reg_we     = 1'b1;
        jump       = 1'b1;
        jlink_sel  = 1'b1;
        jalr_sel   = (opcode == OPC_JALR);
      end
      OPC_BRANCH: begin
        alu_op = ALU_SUB_CMP;
        branch = 1'b1;
      end
      OPC_LOAD: begin
        alu_op     = ALU_ADD;
        alu_src_b  = SRC_IMM;
        mem_to_reg = WB_MEM;
        reg_we     = 1'b1;
        mem_read   = 1'b1;
      end
      OPC_STORE: begin
        alu_op    = ALU_ADD;
        alu_src_b = SRC_IMM;
        mem_write = 1'b1;
      end
      OPC_OP_IMM: begin
        alu_op    = ALU_FUNCT;
        alu_src_b = SRC_IMM;
        reg_we    = 1'b1;
      end
      OPC_OP: begin
        alu_op = ALU_FUNCT;
        reg_we = 1'b1;
      end
      OPC_SYSTEM: begin
        case (funct3[1:0])
          csr_rw:         csr_we = 1'b1;
          csr_rs, csr_rc: csr_we = rs1_nz;  // x0 source means read only
          default:        csr_we = 1'b0;    // ecall / ebreak
        endcase
        if (funct3[1:0] != 2'b00) begin
          csr_rd     = 1'b1;
          reg_we     = 1'b1;
          mem_to_reg = WB_CSR;
          alu_src_b  = SRC_ZERO;  // rs1 passes through to the csr unit
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: src/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage import rv_pkg::*; #(
  parameter int DWIDTH   = xlen,
  parameter int PC_WIDTH = xlen
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [PC_WIDTH-1:0] pc,
  input  logic [ilen-1:0]     inst,
  input  logic                wb_we,
  input  logic [reg_aw-1:0]   wb_addr,
  input  logic [DWIDTH-1:0]   wb_data,
  output logic [DWIDTH-1:0]   data_rs1,
  output logic [DWIDTH-1:0]   data_rs2,
  output logic [DWIDTH-1:0]   data_utype,
  output logic [DWIDTH-1:0]   data_imm,
  output logic [PC_WIDTH-1:0] branch_pc_new,
  output logic [csr_aw-1:0]   csr_addr,
  output logic [2:0]          csr_func,
  output alu_op_e             alu_op,
  output alu_src_e            alu_src_a,
  output alu_src_e            alu_src_b,
  output wb_src_e             mem_to_reg,
  output logic                reg_we,
  output logic                mem_write,
  output logic                mem_read,
  output logic                csr_we,
  output logic                csr_rd,
  output logic                pc_src,
  output logic                id_flush
);

  logic [DWIDTH-1:0]   imm;
  logic [PC_WIDTH-1:0] target_base;

  // controls straight from the decoder, before squash gating
  alu_op_e  alu_op_raw;
  alu_src_e alu_src_a_raw, alu_src_b_raw;
  wb_src_e  mem_to_reg_raw;
  logic     reg_we_raw, mem_write_raw, mem_read_raw;
  logic     csr_we_raw, csr_rd_raw;
  logic     branch, jump, jalr_sel, utype_sel, jlink_sel;
  logic     taken, zero_sel;

  reg_file #(.AWIDTH(reg_aw), .DWIDTH(DWIDTH)) u_reg_file (
    .clk   (clk),
    .arst_n(arst_n),
    .we    (wb_we),
    .waddr (wb_addr),
    .wdata (wb_data),
    .raddr1(inst[19:15]),
    .raddr2(inst[24:20]),
    .rdata1(data_rs1),
    .rdata2(data_rs2)
  );

  imm_gen #(.DWIDTH(DWIDTH)) u_imm_gen (
    .inst(inst),
    .imm (imm)
  );

  control_unit u_control_unit (
    .inst      (inst),
    .alu_op    (alu_op_raw),
    .alu_src_a (alu_src_a_raw),
    .alu_src_b (alu_src_b_raw),
    .mem_to_reg(mem_to_reg_raw),
    .reg_we    (reg_we_raw),
    .mem_write (mem_write_raw),
    .mem_read  (mem_read_raw),
    .branch    (branch),
    .jump      (jump),
    .jalr_sel  (jalr_sel),
    .utype_sel (utype_sel),
    .jlink_sel (jlink_sel),
    .csr_we    (csr_we_raw),
    .csr_rd    (csr_rd_raw)
  );

  branch_cmp #(.DWIDTH(DWIDTH)) u_branch_cmp (
    .rs1   (data_rs1),
    .rs2   (data_rs2),
    .funct3(inst[14:12]),
    .taken (taken)
  );

  assign pc_src   = jump | (branch & taken);  // resolved here, no ex stage compare
  assign id_flush = pc_src;

  hazard_unit u_hazard_unit (
    .clk     (clk),
    .arst_n  (arst_n),
    .pc_src  (pc_src),
    .zero_sel(zero_sel)
  );

  // squashed slot goes down the pipe as a bubble
  assign alu_op     = zero_sel ? ALU_NONE : alu_op_raw;
  assign alu_src_a  = zero_sel ? SRC_REG  : alu_src_a_raw;
  assign alu_src_b  = zero_sel ? SRC_REG  : alu_src_b_raw;
  assign mem_to_reg = zero_sel ? WB_ALU   : mem_to_reg_raw;
  assign reg_we     = reg_we_raw    & ~zero_sel;
  assign mem_write  = mem_write_raw & ~zero_sel;
  assign mem_read   = mem_read_raw  & ~zero_sel;
  assign csr_we     = csr_we_raw    & ~zero_sel;
  assign csr_rd     = csr_rd_raw    & ~zero_sel;

  // jalr jumps off rs1, everything else off pc
  assign target_base   = jalr_sel ? PC_WIDTH'(data_rs1) : pc;
  assign branch_pc_new = target_base + PC_WIDTH'(imm);

  assign data_utype = utype_sel ? DWIDTH'(pc) : '0;  // auipc adds to pc
  assign data_imm   = jlink_sel ? DWIDTH'(4) : imm;  // link value is pc + 4

  assign csr_addr = inst[31:20];
  assign csr_func = inst[14:12];

endmodule

`default_nettype wire

// File: src/decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top import rv_pkg::*; #(
  parameter int DWIDTH   = xlen,
  parameter int PC_WIDTH = xlen
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic [PC_WIDTH-1:0] pc,
  input  logic [ilen-1:0]     inst,
  input  logic                wb_we,
  input  logic [reg_aw-1:0]   wb_addr,
  input  logic [DWIDTH-1:0]   wb_data,
  output logic [DWIDTH-1:0]   ex_data_rs1,
  output logic [DWIDTH-1:0]   ex_data_rs2,
  output logic [DWIDTH-1:0]   ex_data_utype,
  output logic [DWIDTH-1:0]   ex_data_imm,
  output logic [csr_aw-1:0]   ex_csr_addr,
  output logic [2:0]          ex_csr_func,
  output alu_op_e             ex_alu_op,
  output alu_src_e            ex_alu_src_a,
  output alu_src_e            ex_alu_src_b,
  output wb_src_e             ex_mem_to_reg,
  output logic                ex_reg_we,
  output logic                ex_mem_write,
  output logic                ex_mem_read,
  output logic                ex_csr_we,
  output logic                ex_csr_rd,
  output logic                pc_src,         // redirect to fetch
  output logic [PC_WIDTH-1:0] branch_pc_new,
  output logic                id_flush        // kills the if/id slot
);

  // decode packet between the two halves
  logic [DWIDTH-1:0] data_rs1, data_rs2, data_utype, data_imm;
  logic [csr_aw-1:0] csr_addr;
  logic [2:0]        csr_func;
  alu_op_e           alu_op;
  alu_src_e          alu_src_a, alu_src_b;
  wb_src_e           mem_to_reg;
  logic              reg_we, mem_write, mem_read, csr_we, csr_rd;

  // port names line up on both sides
  decode_stage #(.DWIDTH(DWIDTH), .PC_WIDTH(PC_WIDTH)) u_decode_stage (.*);

  id_ex_reg #(.DWIDTH(DWIDTH), .PC_WIDTH(PC_WIDTH)) u_id_ex_reg (.*);

endmodule

`default_nettype wire

// File: src/hazard_unit.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_unit (
  input  logic clk,
  input  logic arst_n,
  input  logic pc_src,
  output logic zero_sel
);

  // the instruction fetched behind a redirect sits in decode next cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      zero_sel <= 1'b0;
    end else begin
      zero_sel <= pc_src;
    end
  end

endmodule

`default_nettype wire

// File: src/id_ex_reg.sv
`timescale 1ns/100ps
`default_nettype none

module id_ex_reg import rv_pkg::*; #(
  parameter int DWIDTH   = xlen,
  parameter int PC_WIDTH = xlen
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic [DWIDTH-1:0] data_rs1,
  input  logic [DWIDTH-1:0] data_rs2,
  input  logic [DWIDTH-1:0] data_utype,
  input  logic [DWIDTH-1:0] data_imm,
  input  logic [csr_aw-1:0] csr_addr,
  input  logic [2:0]        csr_func,
  input  alu_op_e           alu_op,
  input  alu_src_e          alu_src_a,
  input  alu_src_e          alu_src_b,
  input  wb_src_e           mem_to_reg,
  input  logic              reg_we,
  input  logic              mem_write,
  input  logic              mem_read,
  input  logic              csr_we,
  input  logic              csr_rd,
  output logic [DWIDTH-1:0] ex_data_rs1,
  output logic [DWIDTH-1:0] ex_data_rs2,
  output logic [DWIDTH-1:0] ex_data_utype,
  output logic [DWIDTH-1:0] ex_data_imm,
  output logic [csr_aw-1:0] ex_csr_addr,
  output logic [2:0]        ex_csr_func,
  output alu_op_e           ex_alu_op,
  output alu_src_e          ex_alu_src_a,
  output alu_src_e          ex_alu_src_b,
  output wb_src_e           ex_mem_to_reg,
  output logic              ex_reg_we,
  output logic              ex_mem_write,
  output logic              ex_mem_read,
  output logic              ex_csr_we,
  output logic              ex_csr_rd
);

  // one slot, loads every cycle
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_data_rs1   <= '0;
      ex_data_rs2   <= '0;
      ex_data_utype <= '0;
      ex_data_imm   <= '0;
      ex_csr_addr   <= '0;
      ex_csr_func   <= '0;
      ex_alu_op     <= ALU_NONE;
      ex_alu_src_a  <= SRC_REG;
      ex_alu_src_b  <= SRC_REG;
      ex_mem_to_reg <= WB_ALU;
      ex_reg_we     <= 1'b0;
      ex_mem_write  <= 1'b0;
      ex_mem_read   <= 1'b0;
      ex_csr_we     <= 1'b0;
      ex_csr_rd     <= 1'b0;
    end else begin
      ex_data_rs1   <= data_rs1;
      ex_data_rs2   <= data_rs2;
      ex_data_utype <= data_utype;
      ex_data_imm   <= data_imm;
      ex_csr_addr   <= csr_addr;
      ex_csr_func   <= csr_func;
      ex_alu_op     <= alu_op;
      ex_alu_src_a  <= alu_src_a;
      ex_alu_src_b  <= alu_src_b;
      ex_mem_to_reg <= mem_to_reg;
      ex_reg_we     <= reg_we;
      ex_mem_write  <= mem_write;
      ex_mem_read   <= mem_read;
      ex_csr_we     <= csr_we;
      ex_csr_rd     <= csr_rd;
    end
  end

endmodule

`default_nettype wire

// File: src/imm_gen.sv
`timescale 1ns/100ps
`default_nettype none

module imm_gen import rv_pkg::*; #(
  parameter int DWIDTH = xlen
) (
  input  logic [ilen-1:0]   inst,
  output logic [DWIDTH-1:0] imm
);

  logic signed [ilen-1:0] imm32;

  always_comb begin
    case (opcode_e'(inst[6:0]))
      OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
        imm32 = {{20{inst[31]}}, inst[31:20]};
      end
      OPC_STORE: begin
        imm32 = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      OPC_BRANCH: begin
        imm32 = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_LUI, OPC_AUIPC: begin
        imm32 = {inst[31:12], 12'b0};
      end
      OPC_JAL: begin
        imm32 = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: imm32 = '0;  // r-type and system carry no immediate
    endcase
  end

  // signed cast extends past 32 bits when DWIDTH is wider
  assign imm = DWIDTH'(imm32);

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file import rv_pkg::*; #(
  parameter int AWIDTH = reg_aw,
  parameter int DWIDTH = xlen
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              we,
  input  logic [AWIDTH-1:0] waddr,
  input  logic [DWIDTH-1:0] wdata,
  input  logic [AWIDTH-1:0] raddr1,
  input  logic [AWIDTH-1:0] raddr2,
  output logic [DWIDTH-1:0] rdata1,
  output logic [DWIDTH-1:0] rdata2
);

  logic [DWIDTH-1:0] regs [2**AWIDTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 2**AWIDTH; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin  // x0 stays zero
      regs[waddr] <= wdata;
    end
  end

  // no bypass, a write shows up on the next cycle
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
`default_nettype none

package rv_pkg;

  localparam int unsigned xlen   = 32;  // data and pc width
  localparam int unsigned ilen   = 32;  // instruction word
  localparam int unsigned reg_aw = 5;   // 32 architectural registers
  localparam int unsigned csr_aw = 12;

  // rv32i major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [1:0] {
    ALU_NONE    = 2'd0,  // idle, also the squash value
    ALU_ADD     = 2'd1,
    ALU_SUB_CMP = 2'd2,
    ALU_FUNCT   = 2'd3   // execute looks at funct3/funct7
  } alu_op_e;

  typedef enum logic [1:0] {
    SRC_REG  = 2'd0,
    SRC_PC   = 2'd1,
    SRC_IMM  = 2'd2,
    SRC_ZERO = 2'd3
  } alu_src_e;

  typedef enum logic [1:0] {
    WB_ALU = 2'd0,
    WB_MEM = 2'd1,
    WB_PC4 = 2'd2,
    WB_CSR = 2'd3
  } wb_src_e;

  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } branch_f3_e;

  // system funct3 low bits, bit 2 only picks the zimm form
  localparam logic [1:0] csr_rw = 2'b01;
  localparam logic [1:0] csr_rs = 2'b10;
  localparam logic [1:0] csr_rc = 2'b11;

endpackage

`default_nettype wire
